//--- hdl/video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// ----------------------------------------
// Horizontal raster, in pixels
// ----------------------------------------

`define H_ACTIVE    640
`define H_FRONT     16
`define H_SYNC      96
`define H_BACK      48
`define H_TOTAL     (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// ----------------------------------------
// Vertical raster, in lines
// ----------------------------------------

`define V_ACTIVE    480
`define V_FRONT     10
`define V_SYNC      2
`define V_BACK      33
`define V_TOTAL     (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// Position counter widths
`define W_X         10
`define W_Y         10

// One colour bar, must stay a power of two for the gradient
`define BAND_WIDTH  128

// Board colour widths
`define W_RED       8
`define W_GREEN     8
`define W_BLUE      8

`endif

//--- hdl/video_pkg.sv
`default_nettype none

package video_pkg;

    // ----------------------------------------
    // Pixel payload
    // ----------------------------------------

    // 4 bits per channel, widened only at the output
    typedef struct packed
    {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pixel_rgb4_t;

    // ----------------------------------------
    // Sync payload
    // ----------------------------------------

    // Syncs are active low
    typedef struct packed
    {
        logic hsync;
        logic vsync;
        logic display_on;
    } sync_t;

endpackage

`default_nettype wire

//--- hdl/display_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_macros.svh"

module display_timing
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pix_stb,

    output logic [`W_X - 1:0]   x,
    output logic [`W_Y - 1:0]   y,

    output logic                hsync,
    output logic                vsync,
    output logic                display_on
);

    // ----------------------------------------
    // Raster limits
    // ----------------------------------------

    localparam logic [`W_X - 1:0] x_last    = `W_X'(`H_TOTAL - 1);
    localparam logic [`W_Y - 1:0] y_last    = `W_Y'(`V_TOTAL - 1);

    localparam logic [`W_X - 1:0] x_active  = `W_X'(`H_ACTIVE);
    localparam logic [`W_Y - 1:0] y_active  = `W_Y'(`V_ACTIVE);

    // Sync pulse follows the front porch
    localparam logic [`W_X - 1:0] hs_start  = `W_X'(`H_ACTIVE + `H_FRONT);
    localparam logic [`W_X - 1:0] hs_end    = `W_X'(`H_ACTIVE + `H_FRONT + `H_SYNC);

    localparam logic [`W_Y - 1:0] vs_start  = `W_Y'(`V_ACTIVE + `V_FRONT);
    localparam logic [`W_Y - 1:0] vs_end    = `W_Y'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    // ----------------------------------------
    // Position counters
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            x <= '0;
            y <= '0;
        end
        else if (pix_stb)
        begin
            if (x == x_last)
            begin
                x <= '0;

                // New line, and new frame after the last line
                if (y == y_last)
                    y <= '0;
                else
                    y <= y + 1'b1;
            end
            else
            begin
                x <= x + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Region decode
    // ----------------------------------------

    // Low inside the pulse window
    assign hsync      = !((x >= hs_start) && (x < hs_end));
    assign vsync      = !((y >= vs_start) && (y < vs_end));

    assign display_on = (x < x_active) && (y < y_active);

endmodule

`default_nettype wire

//--- hdl/bar_pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_macros.svh"

module bar_pattern_gen
(
    input  logic [`W_X - 1:0]       x,
    output video_pkg::pixel_rgb4_t  pixel
);

    // ----------------------------------------
    // Band edges
    // ----------------------------------------

    localparam logic [`W_X - 1:0] edge_1 = `W_X'(1 * `BAND_WIDTH);
    localparam logic [`W_X - 1:0] edge_2 = `W_X'(2 * `BAND_WIDTH);
    localparam logic [`W_X - 1:0] edge_3 = `W_X'(3 * `BAND_WIDTH);
    localparam logic [`W_X - 1:0] edge_4 = `W_X'(4 * `BAND_WIDTH);
    localparam logic [`W_X - 1:0] edge_5 = `W_X'(5 * `BAND_WIDTH);

    // Ramp restarts in every band, 16 steps of 8 pixels
    logic [3:0] gradient;

    assign gradient = x[6:3];

    // ----------------------------------------
    // Colour select
    // ----------------------------------------

    always_comb
    begin
        pixel = '0;

        if (x < edge_1)
        begin
            pixel.red = gradient;
        end
        else if (x < edge_2)
        begin
            pixel.green = gradient;
        end
        else if (x < edge_3)
        begin
            pixel.blue = gradient;
        end
        else if (x < edge_4)
        begin
            // Yellow
            pixel.red   = gradient;
            pixel.green = gradient;
        end
        else if (x < edge_5)
        begin
            // Cyan
            pixel.green = gradient;
            pixel.blue  = gradient;
        end
    end

endmodule

`default_nettype wire

//--- hdl/stage_delay.sv
`timescale 1ns/1ps
`default_nettype none

module stage_delay
#(
    parameter type          T     = logic [7:0],
    parameter int unsigned  DEPTH = 1
)
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pix_stb,

    input  T        data_in,
    output T        data_out,

    input  T        reset_value
);

    T stage [DEPTH];

    // Shift chain, moves only on a strobe
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < DEPTH; i++)
                stage[i] <= reset_value;
        end
        else if (pix_stb)
        begin
            stage[0] <= data_in;

            for (int i = 1; i < DEPTH; i++)
                stage[i] <= stage[i - 1];
        end
    end

    assign data_out = stage[DEPTH - 1];

endmodule

`default_nettype wire

//--- hdl/rgb_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_macros.svh"

module rgb_output_stage
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pix_stb,

    input  video_pkg::pixel_rgb4_t  pixel,
    input  video_pkg::sync_t        sync,

    output logic [`W_RED   - 1:0]   red,
    output logic [`W_GREEN - 1:0]   green,
    output logic [`W_BLUE  - 1:0]   blue,

    output logic                    hsync,
    output logic                    vsync
);

    // ----------------------------------------
    // Widening
    // ----------------------------------------

    // Nibble into the top bits, rest zero
    logic [`W_RED   - 1:0] red_wide;
    logic [`W_GREEN - 1:0] green_wide;
    logic [`W_BLUE  - 1:0] blue_wide;

    assign red_wide   = { pixel.red,   { (`W_RED   - 4) { 1'b0 } } };
    assign green_wide = { pixel.green, { (`W_GREEN - 4) { 1'b0 } } };
    assign blue_wide  = { pixel.blue,  { (`W_BLUE  - 4) { 1'b0 } } };

    // ----------------------------------------
    // Output registers
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end
        else if (pix_stb)
        begin
            // Blanking outside the visible area
            red   <= sync.display_on ? red_wide   : '0;
            green <= sync.display_on ? green_wide : '0;
            blue  <= sync.display_on ? blue_wide  : '0;
            hsync <= sync.hsync;
            vsync <= sync.vsync;
        end
    end

endmodule

`default_nettype wire

//--- hdl/video_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_macros.svh"

module video_top
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pix_stb,

    output logic [`W_RED   - 1:0]   red,
    output logic [`W_GREEN - 1:0]   green,
    output logic [`W_BLUE  - 1:0]   blue,

    output logic                    hsync,
    output logic                    vsync
);

    import video_pkg::*;

    // Idle values loaded by reset
    localparam pixel_rgb4_t pixel_black = '0;
    localparam sync_t       sync_idle   = '{hsync: 1'b1, vsync: 1'b1, display_on: 1'b0};

    logic [`W_X - 1:0] x;

    logic              timing_hsync;
    logic              timing_vsync;
    logic              timing_display_on;

    pixel_rgb4_t       pattern_pixel;
    pixel_rgb4_t       delayed_pixel;
    sync_t             timing_sync;
    sync_t             delayed_sync;

    // ----------------------------------------
    // Raster timing and pattern
    // ----------------------------------------

    // Pattern depends on x only, so the line count stays inside the timing block
    display_timing u_timing
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_stb    (pix_stb),
        .x          (x),
        .y          (),
        .hsync      (timing_hsync),
        .vsync      (timing_vsync),
        .display_on (timing_display_on)
    );

    bar_pattern_gen u_pattern
    (
        .x          (x),
        .pixel      (pattern_pixel)
    );

    assign timing_sync = '{hsync: timing_hsync, vsync: timing_vsync,
                           display_on: timing_display_on};

    // ----------------------------------------
    // Pipeline
    // ----------------------------------------

    stage_delay #(.T(pixel_rgb4_t), .DEPTH(1)) u_pixel_delay
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_stb     (pix_stb),
        .data_in     (pattern_pixel),
        .data_out    (delayed_pixel),
        .reset_value (pixel_black)
    );

    stage_delay #(.T(sync_t), .DEPTH(1)) u_sync_delay
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_stb     (pix_stb),
        .data_in     (timing_sync),
        .data_out    (delayed_sync),
        .reset_value (sync_idle)
    );

    rgb_output_stage u_output
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_stb    (pix_stb),
        .pixel      (delayed_pixel),
        .sync       (delayed_sync),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .hsync      (hsync),
        .vsync      (vsync)
    );

endmodule

`default_nettype wire

//--- verification/video_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_macros.svh"

module video_tb;

    import video_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 10;

    // 1.1 frames worth of strobes
    localparam int TOTAL_STROBES   = (`H_TOTAL * `V_TOTAL * 11) / 10;

    // Roughly 1.6 clocks per strobe once the random gaps are counted
    localparam int EXPECTED_CYCLES = RESET_CYCLES + (TOTAL_STROBES * 8) / 5;
    localparam int GAP_LENGTH      = 32;

    localparam pixel_rgb4_t PIXEL_BLACK = '0;
    localparam sync_t       SYNC_IDLE   = '{hsync: 1'b1, vsync: 1'b1, display_on: 1'b0};

    logic                  clk;
    logic                  rst_n;
    logic                  pix_stb;

    logic [`W_RED   - 1:0] red;
    logic [`W_GREEN - 1:0] green;
    logic [`W_BLUE  - 1:0] blue;
    logic                  hsync;
    logic                  vsync;

    // Reference model state
    int                    model_x;
    int                    model_y;
    pixel_rgb4_t           pixel_queue [$];
    sync_t                 sync_queue [$];

    logic [31:0]           lcg_state;
    int                    strobe_count;
    int                    posedge_count;

    video_top dut0
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .pix_stb (pix_stb),
        .red     (red),
        .green   (green),
        .blue    (blue),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Colour as seen at the output, blanking already applied
    function automatic pixel_rgb4_t expected_pixel(input int px, input int py);
        pixel_rgb4_t p;
        logic [3:0]  level;
        p     = PIXEL_BLACK;
        level = 4'((px % `BAND_WIDTH) / 8);
        if (px < `H_ACTIVE && py < `V_ACTIVE)
        begin
            case (px / `BAND_WIDTH)
                0: p.red = level;
                1: p.green = level;
                2: p.blue = level;
                3:
                begin
                    p.red   = level;
                    p.green = level;
                end
                4:
                begin
                    p.green = level;
                    p.blue  = level;
                end
                default: p = PIXEL_BLACK;
            endcase
        end
        return p;
    endfunction

    function automatic sync_t expected_sync(input int px, input int py);
        sync_t s;
        int    hs_start;
        int    vs_start;
        hs_start     = `H_ACTIVE + `H_FRONT;
        vs_start     = `V_ACTIVE + `V_FRONT;
        s.hsync      = !(px >= hs_start && px < hs_start + `H_SYNC);
        s.vsync      = !(py >= vs_start && py < vs_start + `V_SYNC);
        s.display_on = (px < `H_ACTIVE) && (py < `V_ACTIVE);
        return s;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    // Upper nibble carries the colour, lower bits must stay clear
    task automatic check_pixel(input pixel_rgb4_t exp, input logic [`W_RED - 1:0] r,
                               input logic [`W_GREEN - 1:0] g, input logic [`W_BLUE - 1:0] b);
        pixel_rgb4_t got;
        logic        low_clear;
        got.red   = r[`W_RED - 1 -: 4];
        got.green = g[`W_GREEN - 1 -: 4];
        got.blue  = b[`W_BLUE - 1 -: 4];
        low_clear = (r[`W_RED - 5:0] == '0) && (g[`W_GREEN - 5:0] == '0)
                    && (b[`W_BLUE - 5:0] == '0);
        if (got !== exp || low_clear !== 1'b1)
            abort_run($sformatf("FAIL at %0d ns: colour %h %h %h, expected nibbles %h %h %h",
                                $time, r, g, b, exp.red, exp.green, exp.blue));
    endtask

    task automatic check_sync(input sync_t exp, input logic hs, input logic vs);
        if (hs !== exp.hsync || vs !== exp.vsync)
            abort_run($sformatf("FAIL at %0d ns: hsync %b vsync %b, expected %b %b",
                                $time, hs, vs, exp.hsync, exp.vsync));
    endtask

    // ----------------------------------------
    // Model and checks
    // ----------------------------------------

    // Outputs are read before this edge updates them
    always @(posedge clk)
    begin
        posedge_count = posedge_count + 1;
        if (!rst_n)
        begin
            model_x = 0;
            model_y = 0;
            pixel_queue.delete();
            sync_queue.delete();
            pixel_queue.push_back(PIXEL_BLACK);
            pixel_queue.push_back(PIXEL_BLACK);
            sync_queue.push_back(SYNC_IDLE);
            sync_queue.push_back(SYNC_IDLE);
        end

        // First edge only loads the reset state
        if (posedge_count > 1)
        begin
            check_pixel(pixel_queue[0], red, green, blue);
            check_sync(sync_queue[0], hsync, vsync);
        end

        if (rst_n && pix_stb)
        begin
            pixel_queue.push_back(expected_pixel(model_x, model_y));
            sync_queue.push_back(expected_sync(model_x, model_y));
            void'(pixel_queue.pop_front());
            void'(sync_queue.pop_front());
            if (model_x == `H_TOTAL - 1)
            begin
                model_x = 0;
                model_y = (model_y == `V_TOTAL - 1) ? 0 : model_y + 1;
            end
            else
                model_x = model_x + 1;
            strobe_count = strobe_count + 1;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial
    begin
        int gap_left;
        clk           = 1'b0;
        rst_n         = 1'b0;
        pix_stb       = 1'b0;
        lcg_state     = 32'd11;
        gap_left      = 0;
        strobe_count  = 0;
        posedge_count = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (strobe_count < TOTAL_STROBES)
        begin
            lcg_state = lcg_next(lcg_state);
            if (gap_left > 0)
            begin
                pix_stb  = 1'b0;
                gap_left = gap_left - 1;
            end
            else if (lcg_state[31:24] == 8'h00)
            begin
                // Rare long pause in the strobe
                pix_stb  = 1'b0;
                gap_left = GAP_LENGTH - 1;
            end
            else
                pix_stb = (lcg_state < 32'hC000_0000);
            @(negedge clk);
        end

        pix_stb = 1'b0;
        repeat (4) @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(2 * EXPECTED_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired because the stimulus never finished");
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/video_pkg.sv
hdl/display_timing.sv
hdl/bar_pattern_gen.sv
hdl/stage_delay.sv
hdl/rgb_output_stage.sv
hdl/video_top.sv
verification/video_tb.sv

//--- Bender.yml
package:
  name: video_bars

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/video_pkg.sv
      - hdl/display_timing.sv
      - hdl/bar_pattern_gen.sv
      - hdl/stage_delay.sv
      - hdl/rgb_output_stage.sv
      - hdl/video_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/video_tb.sv
